//--- lsu_pkg.sv
/*
 * LSU widths and the typedefs that carry them
 * Access size enum, command struct, writeback info struct
 */

package lsu_pkg;

  // Address and data path widths
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  // Byte lanes per data word
  localparam int BE_W     = 4;
  // Byte offset inside one word
  localparam int OFFSET_W = 2;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [BE_W-1:0]     be_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // Encoding follows the funct3 size bits of RISC-V loads and stores
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  // One load or store from the execute stage
  typedef struct packed {
    addr_t     op_a;   // Base register
    addr_t     op_b;   // Immediate offset
    data_t     wdata;  // Store data, unaligned
    logic      we;
    lsu_size_e size;
    logic      sext;   // Sign-extend on load
  } lsu_cmd_t;

  // Control info of one transfer in flight, consumed at its response
  typedef struct packed {
    lsu_size_e size;
    logic      sext;
    logic      we;
    offset_t   offset;  // Offset of the original address
    logic      first;   // First half of a split access
    logic      last;    // Last transfer of the access
  } wb_info_t;

endpackage

//--- mem_bus_pkg.sv
/*
 * Data bus request and response structs
 * Outstanding transfer limit and counter type
 */

package mem_bus_pkg;

  // At most this many granted transfers wait for a response
  localparam int DEPTH = 2;
  // Counter must hold 0 to DEPTH
  localparam int CNT_W = 2;

  typedef logic [CNT_W-1:0] cnt_t;

  // Address phase payload
  // Held stable from request until grant
  typedef struct packed {
    lsu_pkg::addr_t addr;
    logic           we;
    lsu_pkg::be_t   be;
    lsu_pkg::data_t wdata;
  } bus_req_t;

  // Response phase payload
  // Responses come back in request order
  typedef struct packed {
    lsu_pkg::data_t rdata;
  } bus_rsp_t;

endpackage

//--- lsu_req_align.sv
/*
 * Request side datapath: effective address, split detection,
 * byte enables and byte-lane rotation of the store data
 */

`timescale 1ns/100ps

module lsu_req_align (
  input  lsu_pkg::lsu_cmd_t    cmd_i,
  input  logic                 split_q_i,
  output logic                 split_needed_o,
  output lsu_pkg::offset_t     offset_o,
  output mem_bus_pkg::bus_req_t bus_o
);

  import lsu_pkg::*;

  addr_t             addr;
  offset_t           offset;
  addr_t             addr_next_word;
  be_t               size_mask;
  logic [2*BE_W-1:0] be_wide;
  logic [2*DATA_W-1:0] wdata_wide;

  ////////////////////////////////////////////////////////////////////////////
  // Address generation
  ////////////////////////////////////////////////////////////////////////////

  // Effective address
  assign addr   = cmd_i.op_a + cmd_i.op_b;
  assign offset = addr[OFFSET_W-1:0];

  // Word after the one holding the first byte
  assign addr_next_word = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} + ADDR_W'(BE_W);

  // Split only in the first phase
  // Word crosses a boundary at any nonzero offset, half-word only at offset 3
  always_comb begin
    split_needed_o = 1'b0;
    if (!split_q_i) begin
      case (cmd_i.size)
        LSU_SIZE_WORD: split_needed_o = (offset != '0);
        LSU_SIZE_HALF: split_needed_o = (offset == '1);
        default:       split_needed_o = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////////////

  // Lanes touched by the access, before the offset
  always_comb begin
    case (cmd_i.size)
      LSU_SIZE_BYTE: size_mask = 4'b0001;
      LSU_SIZE_HALF: size_mask = 4'b0011;
      default:       size_mask = 4'b1111;
    endcase
  end

  // Lanes over two words
  // Low half for the first transfer, high half for the remainder of a split
  assign be_wide = {{BE_W{1'b0}}, size_mask} << offset;

  // Rotate store data left by the offset in bytes
  assign wdata_wide = {cmd_i.wdata, cmd_i.wdata} << {offset, 3'b000};

  ////////////////////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_o.addr  = split_q_i ? addr_next_word : addr;
    bus_o.we    = cmd_i.we;
    bus_o.be    = split_q_i ? be_wide[2*BE_W-1:BE_W] : be_wide[BE_W-1:0];
    // Same rotation serves both halves, lanes select the bytes
    bus_o.wdata = wdata_wide[2*DATA_W-1:DATA_W];
  end

  // Offset of the original address, kept for the read side
  assign offset_o = offset;

endmodule

//--- lsu_rdata_align.sv
/*
 * Read data path: joins the two halves of a split load,
 * shifts the result down to bit 0 and sign- or zero-extends it
 */

`timescale 1ns/100ps

module lsu_rdata_align (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rvalid_i,
  input  mem_bus_pkg::bus_rsp_t rsp_i,
  input  lsu_pkg::wb_info_t     info_i,
  output lsu_pkg::data_t        rdata_o
);

  import lsu_pkg::*;

  data_t               rdata_q;
  logic                rdata_is_split;
  logic [2*DATA_W-1:0] rdata_full;
  logic [2*DATA_W-1:0] rdata_shifted;
  data_t               rdata_aligned;

  // Low word of a split load
  // Captured at the first response, joined at the second
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && info_i.first && !info_i.we) begin
      rdata_q <= rsp_i.rdata;
    end
  end

  // Same rule as the request side split
  always_comb begin
    case (info_i.size)
      LSU_SIZE_WORD: rdata_is_split = (info_i.offset != '0);
      LSU_SIZE_HALF: rdata_is_split = (info_i.offset == '1);
      default:       rdata_is_split = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realignment
  ////////////////////////////////////////////////////////////////////////////

  // Second word above the first for a split
  // Otherwise the response twice, so the shift wraps high bytes down
  assign rdata_full = rdata_is_split ? {rsp_i.rdata, rdata_q}
                                     : {rsp_i.rdata, rsp_i.rdata};

  assign rdata_shifted = rdata_full >> {info_i.offset, 3'b000};
  assign rdata_aligned = rdata_shifted[DATA_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (info_i.size)
      LSU_SIZE_BYTE: begin
        rdata_o = {{24{info_i.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
      LSU_SIZE_HALF: begin
        rdata_o = {{16{info_i.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: begin
        rdata_o = rdata_aligned;
      end
    endcase
  end

endmodule

//--- lsu_ctrl.sv
/*
 * LSU control with the split state, the outstanding transfer counter,
 * the writeback info queue and the command and bus handshakes
 */

`timescale 1ns/100ps

module lsu_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t cmd_i,
  input  logic              split_needed_i,
  input  lsu_pkg::offset_t  offset_i,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  output logic              split_q_o,
  output logic              bus_req_o,
  output logic              cmd_ready_o,
  output lsu_pkg::wb_info_t info_o,
  output logic              rsp_valid_o,
  output logic              rsp_we_o,
  output logic              busy_o
);

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic             gnt;
  cnt_t             cnt_q;
  cnt_t             cnt_next;
  logic             split_q;
  wb_info_t         push_info;
  wb_info_t         info_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Request only with room for one more outstanding transfer
  // Count only falls while waiting so the request holds until its grant
  assign bus_req_o = cmd_valid_i && (cnt_q < cnt_t'(DEPTH));
  assign gnt       = bus_req_o && bus_gnt_i;

  // Command leaves at the grant of its last transfer
  assign cmd_ready_o = gnt && !split_needed_i;

  // Second phase of a split follows the first grant
  // Cleared without a valid command so the next one starts in phase one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!cmd_valid_i) begin
      split_q <= 1'b0;
    end else if (gnt) begin
      split_q <= split_needed_i;
    end
  end

  assign split_q_o = split_q;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case ({gnt, bus_rvalid_i})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;  // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writeback info queue
  ////////////////////////////////////////////////////////////////////////////

  // First half of a split never produces a result
  always_comb begin
    push_info.size   = cmd_i.size;
    push_info.sext   = cmd_i.sext;
    push_info.we     = cmd_i.we;
    push_info.offset = offset_i;
    push_info.first  = split_needed_i;
    push_info.last   = !split_needed_i;
  end

  // One entry written per granted transfer
  always_ff @(posedge clk) begin
    if (gnt) begin
      info_mem[wr_ptr_q] <= push_info;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (gnt) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Head entry belongs to the next response
  assign info_o = info_mem[rd_ptr_q];

  ////////////////////////////////////////////////////////////////////////////
  // Result and status
  ////////////////////////////////////////////////////////////////////////////

  assign rsp_valid_o = bus_rvalid_i && info_o.last;
  assign rsp_we_o    = info_o.we;
  assign busy_o      = cmd_valid_i || (cnt_q != '0);

endmodule

//--- lsu_top.sv
/*
 * LSU top level
 * Control, request datapath and read datapath wired to the ports
 */

`timescale 1ns/100ps

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Execute stage command
  input  logic                   cmd_valid_i,
  input  lsu_pkg::lsu_cmd_t      cmd_i,
  output logic                   cmd_ready_o,
  // Data bus
  output logic                   bus_req_o,
  output mem_bus_pkg::bus_req_t  bus_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  mem_bus_pkg::bus_rsp_t  bus_rsp_i,
  // Writeback result
  output logic                   rsp_valid_o,
  output lsu_pkg::data_t         rsp_rdata_o,
  output logic                   rsp_we_o,
  output logic                   busy_o
);

  import lsu_pkg::*;

  logic     split_q;
  logic     split_needed;
  offset_t  offset;
  wb_info_t info_head;

  // Handshakes, split state and info queue
  lsu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_i          (cmd_i),
    .split_needed_i (split_needed),
    .offset_i       (offset),
    .bus_gnt_i      (bus_gnt_i),
    .bus_rvalid_i   (bus_rvalid_i),
    .split_q_o      (split_q),
    .bus_req_o      (bus_req_o),
    .cmd_ready_o    (cmd_ready_o),
    .info_o         (info_head),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_we_o       (rsp_we_o),
    .busy_o         (busy_o)
  );

  // Address, byte enables and store data, combinational on the command
  lsu_req_align u_req_align (
    .cmd_i          (cmd_i),
    .split_q_i      (split_q),
    .split_needed_o (split_needed),
    .offset_o       (offset),
    .bus_o          (bus_o)
  );

  // Load data, combinational on the response
  lsu_rdata_align u_rdata_align (
    .clk      (clk),
    .rst_n    (rst_n),
    .rvalid_i (bus_rvalid_i),
    .rsp_i    (bus_rsp_i),
    .info_i   (info_head),
    .rdata_o  (rsp_rdata_o)
  );

endmodule

//--- lsu_properties.sv
/*
 * Concurrent checks on the LSU control block bound into lsu_ctrl
 * Outstanding limit, request stability, response and result pulses
 */

`timescale 1ns/100ps

module lsu_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              cmd_ready_i,
  input logic              bus_req_i,
  input logic              bus_gnt_i,
  input logic              bus_rvalid_i,
  input logic              rsp_valid_i,
  input mem_bus_pkg::cnt_t cnt_i
);

  import mem_bus_pkg::*;

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Accepted commands still waiting for their result
  int unsigned open_cmds;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      open_cmds <= 0;
    end else if (cmd_ready_i && !rsp_valid_i) begin
      open_cmds <= open_cmds + 1;
    end else if (rsp_valid_i && !cmd_ready_i) begin
      open_cmds <= open_cmds - 1;
    end
  end

  // Outstanding count never passes the queue depth
  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= cnt_t'(DEPTH))
    else begin
      fail_cnt++;
      $error("Outstanding count %0d above depth", cnt_i);
    end

  // Request is held until granted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_gnt_i |=> bus_req_i)
    else begin
      fail_cnt++;
      $error("Bus request dropped before its grant");
    end

  // A response always belongs to a granted transfer
  a_rsp_pending: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> cnt_i != '0)
    else begin
      fail_cnt++;
      $error("Bus response with no transfer outstanding");
    end

  // Result pulse only in a response cycle and only for an accepted command
  a_result_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_i |-> bus_rvalid_i && open_cmds != 0)
    else begin
      fail_cnt++;
      $error("Result pulse without a response to an accepted command");
    end

endmodule

bind lsu_ctrl lsu_properties u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .cmd_ready_i  (cmd_ready_o),
  .bus_req_i    (bus_req_o),
  .bus_gnt_i    (bus_gnt_i),
  .bus_rvalid_i (bus_rvalid_i),
  .rsp_valid_i  (rsp_valid_o),
  .cnt_i        (cnt_q)
);

//--- tb_lsu.sv
/*
 * LSU testbench with clock and reset, a bus memory model with random
 * grant and response delays, and a command table with expected results
 */

`timescale 1ns/100ps

module tb_lsu;

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  // Base register shared by all commands
  localparam addr_t BASE = 32'h40;

  typedef struct packed {
    lsu_cmd_t cmd;
    data_t    exp;  // Expected load result
    logic [1:0] xfers;  // Bus transfers the access needs
  } entry_t;

  logic     clk;
  logic     rst_n;
  logic     cmd_valid_i;
  lsu_cmd_t cmd_i;
  logic     cmd_ready_o;
  logic     bus_req_o;
  bus_req_t bus_o;
  logic     bus_gnt_i;
  logic     bus_rvalid_i;
  bus_rsp_t bus_rsp_i;
  logic     rsp_valid_o;
  data_t    rsp_rdata_o;
  logic     rsp_we_o;
  logic     busy_o;

  // Memory model state
  data_t       mem [64];
  data_t       rsp_data [$];
  int          rsp_due [$];
  int          gnt_wait = 0;
  logic [31:0] rng = 32'h73873582;
  // Stimulus and bookkeeping
  entry_t      tbl [$];
  int          cyc = 0;
  int          limit = 0;
  int          grants = 0;
  int          exp_grants = 0;
  int          results = 0;
  int          errors = 0;

  lsu_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // 32-bit xorshift for the bus delays
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_entry(input addr_t imm, input logic we, input lsu_size_e size,
                           input logic sext, input data_t wdata, input data_t exp,
                           input logic [1:0] xfers);
    entry_t e;
    e.cmd   = '{op_a: BASE, op_b: imm, wdata: wdata, we: we, size: size, sext: sext};
    e.exp   = exp;
    e.xfers = xfers;
    tbl.push_back(e);
    exp_grants += xfers;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Bus memory model, result monitor and timeout
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [5:0] word;
    int         due;
    if (rst_n) begin
      cyc++;
      if (cyc > limit) begin
        $display("Run timed out after %0d cycles with %0d results", cyc, results);
        $display("test failed");
        $finish;
      end else begin
        // Results come back in command order
        if (rsp_valid_o) begin
          if (results >= tbl.size()) begin
            errors++;
            $display("Result pulse at %0t with no command left to match", $time);
          end else begin
            check_value("rsp_we_o", rsp_we_o, tbl[results].cmd.we);
            if (!tbl[results].cmd.we) begin
              check_value("rsp_rdata_o", rsp_rdata_o, tbl[results].exp);
            end
          end
          results++;
        end
        // Memory reads and writes at the grant
        if (bus_req_o && bus_gnt_i) begin
          word = bus_o.addr[7:2];
          rsp_data.push_back(mem[word]);
          if (bus_o.we) begin
            for (int i = 0; i < BE_W; i++) begin
              if (bus_o.be[i]) begin
                mem[word][8*i +: 8] = bus_o.wdata[8*i +: 8];
              end
            end
          end
          // Answer 1 to 3 cycles after the grant and never overtake
          due = cyc + int'(next_rand() % 3);
          if (rsp_due.size() > 0 && due <= rsp_due[$]) begin
            due = rsp_due[$] + 1;
          end
          rsp_due.push_back(due);
          grants++;
          gnt_wait = int'(next_rand() % 3);
        end else if (bus_req_o && gnt_wait > 0) begin
          gnt_wait--;
        end
        bus_gnt_i <= (gnt_wait == 0);
        if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
          bus_rvalid_i    <= 1'b1;
          bus_rsp_i.rdata <= rsp_data.pop_front();
          void'(rsp_due.pop_front());
        end else begin
          bus_rvalid_i <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rsp_i    = '0;
    // Each byte starts as the low 8 bits of its own address
    for (int w = 0; w < 64; w++) begin
      mem[w] = {8'(4*w+3), 8'(4*w+2), 8'(4*w+1), 8'(4*w)};
    end
    // Immediate, we, size, sext, store data, expected load, transfers
    // Loads of neighbor bytes show which lanes each store touched
    add_entry(32'h00, 1'b1, LSU_SIZE_WORD, 1'b0, 32'h8899AABB, 32'h0, 2'd1);
    add_entry(32'h00, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h8899AABB, 2'd1);
    add_entry(32'h04, 1'b1, LSU_SIZE_HALF, 1'b0, 32'h1234F00D, 32'h0, 2'd1);
    add_entry(32'h04, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h4746F00D, 2'd1);
    add_entry(32'h04, 1'b0, LSU_SIZE_HALF, 1'b1, 32'h0, 32'hFFFFF00D, 2'd1);
    add_entry(32'h0A, 1'b1, LSU_SIZE_BYTE, 1'b0, 32'h00000081, 32'h0, 2'd1);
    add_entry(32'h08, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h4B814948, 2'd1);
    add_entry(32'h0A, 1'b0, LSU_SIZE_BYTE, 1'b1, 32'h0, 32'hFFFFFF81, 2'd1);
    add_entry(32'h0A, 1'b0, LSU_SIZE_BYTE, 1'b0, 32'h0, 32'h00000081, 2'd1);
    // Misaligned half at offset 1 stays in one word
    add_entry(32'h01, 1'b0, LSU_SIZE_HALF, 1'b1, 32'h0, 32'hFFFF99AA, 2'd1);
    add_entry(32'h13, 1'b1, LSU_SIZE_HALF, 1'b0, 32'h0000C3A5, 32'h0, 2'd2);
    add_entry(32'h13, 1'b0, LSU_SIZE_HALF, 1'b0, 32'h0, 32'h0000C3A5, 2'd2);
    add_entry(32'h10, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'hA5525150, 2'd1);
    add_entry(32'h14, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h575655C3, 2'd1);
    add_entry(32'h19, 1'b1, LSU_SIZE_WORD, 1'b0, 32'hDEADBEEF, 32'h0, 2'd2);
    add_entry(32'h19, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'hDEADBEEF, 2'd2);
    add_entry(32'h18, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'hADBEEF58, 2'd1);
    add_entry(32'h1C, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h5F5E5DDE, 2'd1);
    add_entry(32'h22, 1'b1, LSU_SIZE_WORD, 1'b0, 32'h01234567, 32'h0, 2'd2);
    add_entry(32'h22, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h01234567, 2'd2);
    add_entry(32'h20, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h45676160, 2'd1);
    add_entry(32'h24, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h67660123, 2'd1);
    add_entry(32'h2B, 1'b1, LSU_SIZE_WORD, 1'b0, 32'hCAFEF00D, 32'h0, 2'd2);
    add_entry(32'h2B, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'hCAFEF00D, 2'd2);
    add_entry(32'h28, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h0D6A6968, 2'd1);
    add_entry(32'h2C, 1'b0, LSU_SIZE_WORD, 1'b0, 32'h0, 32'h6FCAFEF0, 2'd1);
    add_entry(32'h2D, 1'b0, LSU_SIZE_HALF, 1'b1, 32'h0, 32'hFFFFCAFE, 2'd1);
    limit = 40 * tbl.size() + 20;

    repeat (2) @(posedge clk);
    // Outputs while reset is still applied
    check_value("bus_req_o", bus_req_o, 1'b0);
    check_value("cmd_ready_o", cmd_ready_o, 1'b0);
    check_value("rsp_valid_o", rsp_valid_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    rst_n <= 1'b1;

    foreach (tbl[k]) begin
      cmd_valid_i <= 1'b1;
      cmd_i       <= tbl[k].cmd;
      // Held until the grant of its last transfer
      do begin
        @(posedge clk);
      end while (!cmd_ready_o);
    end
    cmd_valid_i <= 1'b0;

    while (results < tbl.size()) begin
      @(posedge clk);
    end
    @(posedge clk);
    check_value("busy_o", busy_o, 1'b0);
    check_value("result count", results, tbl.size());
    check_value("grant count", grants, exp_grants);

    $display("Done: %0d errors, %0d assertion failures, %0d results, %0d grants",
             errors, u_dut.u_ctrl.u_props.fail_cnt, results, grants);
    if (errors == 0 && u_dut.u_ctrl.u_props.fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sources.f
lsu_pkg.sv
mem_bus_pkg.sv
lsu_req_align.sv
lsu_rdata_align.sv
lsu_ctrl.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - mem_bus_pkg.sv
  - lsu_req_align.sv
  - lsu_rdata_align.sv
  - lsu_ctrl.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_properties.sv
      - tb_lsu.sv
